/* source/cache_settings.svh */
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

`define CACHE_ADDR_BITS        32
`define CACHE_WORD_BITS        32
`define CACHE_INDEX_BITS       4
`define CACHE_WORD_OFFSET_BITS 2

// derived geometry
`define CACHE_SETS             (1 << `CACHE_INDEX_BITS)
`define CACHE_WORDS_PER_LINE   (1 << `CACHE_WORD_OFFSET_BITS)
`define CACHE_STRB_BITS        (`CACHE_WORD_BITS / 8)
`define CACHE_BYTE_SEL_BITS    ($clog2(`CACHE_STRB_BITS))
`define CACHE_BYTE_OFFSET_BITS (`CACHE_WORD_OFFSET_BITS + `CACHE_BYTE_SEL_BITS)
`define CACHE_TAG_BITS         (`CACHE_ADDR_BITS - `CACHE_INDEX_BITS - `CACHE_BYTE_OFFSET_BITS)

`endif

/* source/cache_types_pkg.sv */
`default_nettype none
`include "cache_settings.svh"

package cache_types_pkg;

    typedef logic [`CACHE_ADDR_BITS-1:0]        addr_t;
    typedef logic [`CACHE_WORD_BITS-1:0]        word_t;
    typedef logic [`CACHE_STRB_BITS-1:0]        strb_t;
    typedef logic [`CACHE_TAG_BITS-1:0]         tag_t;
    typedef logic [`CACHE_INDEX_BITS-1:0]       index_t;
    typedef logic [`CACHE_WORD_OFFSET_BITS-1:0] word_off_t;
    typedef word_t [`CACHE_WORDS_PER_LINE-1:0]  line_t;   // word 0 in the low bits

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t wdata;
        strb_t wstrb;
    } req_t;

    // address layout is tag | index | word offset | byte select
    function automatic tag_t addr_tag(addr_t a);
        return a[`CACHE_ADDR_BITS-1 -: `CACHE_TAG_BITS];
    endfunction

    function automatic index_t addr_index(addr_t a);
        return a[`CACHE_BYTE_OFFSET_BITS +: `CACHE_INDEX_BITS];
    endfunction

    function automatic word_off_t addr_word_off(addr_t a);
        return a[`CACHE_BYTE_SEL_BITS +: `CACHE_WORD_OFFSET_BITS];
    endfunction

    function automatic addr_t line_addr(tag_t t, index_t i);
        return {t, i, {`CACHE_BYTE_OFFSET_BITS{1'b0}}};  // line base
    endfunction

endpackage

`default_nettype wire

/* source/cache_ctrl_pkg.sv */
`default_nettype none

package cache_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        RESPOND,
        WB_DATA,   // dirty victim beats out
        WB_WAIT,   // wait for write done
        RD_REQ,
        REFILL,
        FILL
    } ctrl_state_t;

    typedef logic way_t;

endpackage

`default_nettype wire

/* source/cache_ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface cache_ctrl_if
    import cache_types_pkg::*;
    import cache_ctrl_pkg::*;
();
    // lookup results
    logic hit;
    way_t hit_way;
    way_t victim_way;
    logic victim_dirty;
    tag_t victim_tag;

    // controller commands
    req_t req;
    logic load_victim;
    logic wb_shift;
    logic fill;
    logic store_hit;

    modport fsm (
        input  hit, victim_dirty, victim_tag,
        output req, load_victim, wb_shift, fill, store_hit
    );

    modport tags (
        input  req, fill, store_hit,
        output hit, hit_way, victim_way, victim_dirty, victim_tag
    );

    modport data (
        input  req, hit_way, victim_way, load_victim, wb_shift, fill, store_hit
    );

endinterface

`default_nettype wire

/* source/cache_sram.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_settings.svh"

module cache_sram #(
    parameter type entry_t = logic [`CACHE_WORD_BITS-1:0]
) (
    input  wire                         clk,
    input  wire                         rstn,
    input  wire                         i_we,
    input  wire [`CACHE_INDEX_BITS-1:0] i_waddr,
    input  wire entry_t                 i_wdata,
    input  wire [`CACHE_INDEX_BITS-1:0] i_raddr,
    output entry_t                      o_rdata
);
    entry_t mem [`CACHE_SETS];   // one entry per set

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                mem[s] <= '0;
            end
        end else if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata = mem[i_raddr];   // async read

endmodule

`default_nettype wire

/* source/tag_store.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_settings.svh"

module tag_store
    import cache_types_pkg::*;
    import cache_ctrl_pkg::*;
(
    input wire         clk,
    input wire         rstn,
    cache_ctrl_if.tags ctrl
);
    index_t                      index;
    tag_t                        req_tag;
    tag_entry_t                  fill_entry;
    tag_entry_t                  entry [2];
    logic [1:0]                  way_hit;
    way_t                        victim;
    logic [`CACHE_SETS-1:0]      lru_q;     // least recently used way of each set
    logic [`CACHE_SETS-1:0][1:0] dirty_q;

    assign index      = addr_index(ctrl.req.addr);
    assign req_tag    = addr_tag(ctrl.req.addr);
    assign fill_entry = '{valid: 1'b1, tag: req_tag};

    for (genvar w = 0; w < 2; w++) begin : g_way
        cache_sram #(.entry_t(tag_entry_t)) u_tags (
            .clk     (clk),
            .rstn    (rstn),
            .i_we    (ctrl.fill && victim == way_t'(w)),
            .i_waddr (index),
            .i_wdata (fill_entry),
            .i_raddr (index),
            .o_rdata (entry[w])
        );
        assign way_hit[w] = entry[w].valid && (entry[w].tag == req_tag);
    end

    // an empty way 0 is filled first
    assign victim = entry[0].valid ? way_t'(lru_q[index]) : way_t'(1'b0);

    assign ctrl.hit          = |way_hit;
    assign ctrl.hit_way      = way_t'(way_hit[1]);
    assign ctrl.victim_way   = victim;
    assign ctrl.victim_dirty = dirty_q[index][victim];
    assign ctrl.victim_tag   = entry[victim].tag;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru_q   <= '0;
            dirty_q <= '0;
        end else begin
            if (ctrl.hit) begin
                lru_q[index] <= ~ctrl.hit_way;   // other way is now least recently used
            end
            if (ctrl.store_hit) begin
                dirty_q[index][ctrl.hit_way] <= 1'b1;
            end else if (ctrl.fill) begin
                dirty_q[index][victim] <= 1'b0;   // fresh line from memory
            end
        end
    end

endmodule

`default_nettype wire

/* source/line_datapath.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_settings.svh"

module line_datapath
    import cache_types_pkg::*;
    import cache_ctrl_pkg::*;
(
    input  wire         clk,
    input  wire         rstn,
    cache_ctrl_if.data  ctrl,
    input  wire         i_mem_rdata_valid,
    input  wire word_t  i_mem_rdata,
    output word_t       o_mem_wr_data,
    output word_t       o_resp_rdata
);
    index_t    index;
    word_off_t word_off;
    line_t     line_rd [2];
    line_t     hit_line;
    line_t     merged_line;
    line_t     wr_line;
    line_t     refill_q;
    line_t     wb_q;

    assign index    = addr_index(ctrl.req.addr);
    assign word_off = addr_word_off(ctrl.req.addr);
    assign hit_line = line_rd[ctrl.hit_way];
    assign wr_line  = ctrl.fill ? refill_q : merged_line;

    for (genvar w = 0; w < 2; w++) begin : g_way
        cache_sram #(.entry_t(line_t)) u_data (
            .clk     (clk),
            .rstn    (rstn),
            .i_we    ((ctrl.fill && ctrl.victim_way == way_t'(w)) ||
                      (ctrl.store_hit && ctrl.hit_way == way_t'(w))),
            .i_waddr (index),
            .i_wdata (wr_line),
            .i_raddr (index),
            .o_rdata (line_rd[w])
        );
    end

    // byte merge of the store into the hit line
    always_comb begin
        merged_line = hit_line;
        for (int b = 0; b < `CACHE_STRB_BITS; b++) begin
            if (ctrl.req.wstrb[b]) begin
                merged_line[word_off][8*b +: 8] = ctrl.req.wdata[8*b +: 8];
            end
        end
    end

    // beats arrive in word order, first beat ends up in word 0
    always_ff @(posedge clk) begin
        if (i_mem_rdata_valid) begin
            refill_q <= {i_mem_rdata, refill_q[`CACHE_WORDS_PER_LINE-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.load_victim) begin
            wb_q <= line_rd[ctrl.victim_way];
        end else if (ctrl.wb_shift) begin
            wb_q <= {word_t'(0), wb_q[`CACHE_WORDS_PER_LINE-1:1]};  // next word down
        end
    end

    assign o_mem_wr_data = wb_q[0];
    assign o_resp_rdata  = hit_line[word_off];

endmodule

`default_nettype wire

/* source/beat_counter.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_settings.svh"

module beat_counter (
    input  wire  clk,
    input  wire  rstn,
    input  wire  i_clear,
    input  wire  i_step,
    output logic o_last
);
    logic [`CACHE_WORD_OFFSET_BITS-1:0] count_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            count_q <= '0;
        end else if (i_clear) begin
            count_q <= '0;
        end else if (i_step) begin
            count_q <= count_q + 1'b1;   // wraps after the last beat
        end
    end

    assign o_last = &count_q;   // final word of the line

endmodule

`default_nettype wire

/* source/cache_ctrl_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl_fsm
    import cache_types_pkg::*;
    import cache_ctrl_pkg::*;
(
    input  wire         clk,
    input  wire         rstn,
    cache_ctrl_if.fsm   ctrl,
    input  wire         i_req_valid,
    output logic        o_req_ready,
    input  wire         i_req_write,
    input  wire addr_t  i_req_addr,
    input  wire word_t  i_req_wdata,
    input  wire strb_t  i_req_wstrb,
    output logic        o_resp_valid,
    output logic        o_mem_rd_valid,
    input  wire         i_mem_rd_ready,
    output addr_t       o_mem_rd_addr,
    input  wire         i_mem_rdata_valid,
    output logic        o_mem_wr_valid,
    input  wire         i_mem_wr_ready,
    output addr_t       o_mem_wr_addr,
    output logic        o_mem_wr_last,
    input  wire         i_mem_wr_done,
    output logic        o_beat_clear,
    output logic        o_beat_step,
    input  wire         i_beat_last
);
    ctrl_state_t state_q;
    ctrl_state_t state_d;
    req_t        req_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= IDLE;
            req_q   <= '0;
        end else begin
            state_q <= state_d;
            if (i_req_valid && o_req_ready) begin
                req_q <= '{write: i_req_write, addr: i_req_addr,
                           wdata: i_req_wdata, wstrb: i_req_wstrb};
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (i_req_valid) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (ctrl.hit) begin
                    state_d = RESPOND;
                end else if (ctrl.victim_dirty) begin
                    state_d = WB_DATA;
                end else begin
                    state_d = RD_REQ;
                end
            end
            RESPOND: state_d = IDLE;
            WB_DATA: begin
                if (i_mem_wr_ready && i_beat_last) begin
                    state_d = WB_WAIT;
                end
            end
            WB_WAIT: begin
                if (i_mem_wr_done) begin
                    state_d = RD_REQ;
                end
            end
            RD_REQ: begin
                if (i_mem_rd_ready) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (i_mem_rdata_valid && i_beat_last) begin
                    state_d = FILL;
                end
            end
            FILL: state_d = LOOKUP;   // second lookup now hits
            default: state_d = IDLE;
        endcase
    end

    assign o_req_ready    = (state_q == IDLE);
    assign o_resp_valid   = (state_q == RESPOND);
    assign o_mem_rd_valid = (state_q == RD_REQ);
    assign o_mem_wr_valid = (state_q == WB_DATA);
    assign o_mem_wr_last  = o_mem_wr_valid && i_beat_last;
    assign o_mem_rd_addr  = line_addr(addr_tag(req_q.addr), addr_index(req_q.addr));
    assign o_mem_wr_addr  = line_addr(ctrl.victim_tag, addr_index(req_q.addr));  // victim line

    // one counter serves both bursts
    assign o_beat_clear = (state_q == LOOKUP) || (state_q == RD_REQ);
    assign o_beat_step  = (o_mem_wr_valid && i_mem_wr_ready) ||
                          ((state_q == REFILL) && i_mem_rdata_valid);

    assign ctrl.req         = req_q;
    assign ctrl.load_victim = (state_q == LOOKUP) && !ctrl.hit;
    assign ctrl.wb_shift    = o_mem_wr_valid && i_mem_wr_ready;
    assign ctrl.fill        = (state_q == FILL);
    assign ctrl.store_hit   = (state_q == LOOKUP) && ctrl.hit && req_q.write;

endmodule

`default_nettype wire

/* source/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top
    import cache_types_pkg::*;
(
    input  wire         clk,
    input  wire         rstn,
    // request port
    input  wire         i_req_valid,
    output logic        o_req_ready,
    input  wire         i_req_write,
    input  wire addr_t  i_req_addr,
    input  wire word_t  i_req_wdata,
    input  wire strb_t  i_req_wstrb,
    output logic        o_resp_valid,
    output word_t       o_resp_rdata,
    // memory read burst
    output logic        o_mem_rd_valid,
    input  wire         i_mem_rd_ready,
    output addr_t       o_mem_rd_addr,
    input  wire         i_mem_rdata_valid,
    input  wire word_t  i_mem_rdata,
    // memory write burst
    output logic        o_mem_wr_valid,
    input  wire         i_mem_wr_ready,
    output addr_t       o_mem_wr_addr,
    output word_t       o_mem_wr_data,
    output logic        o_mem_wr_last,
    input  wire         i_mem_wr_done
);
    logic beat_clear;
    logic beat_step;
    logic beat_last;

    cache_ctrl_if ctrl_if ();

    cache_ctrl_fsm u_fsm (
        .clk               (clk),
        .rstn              (rstn),
        .ctrl              (ctrl_if.fsm),
        .i_req_valid       (i_req_valid),
        .o_req_ready       (o_req_ready),
        .i_req_write       (i_req_write),
        .i_req_addr        (i_req_addr),
        .i_req_wdata       (i_req_wdata),
        .i_req_wstrb       (i_req_wstrb),
        .o_resp_valid      (o_resp_valid),
        .o_mem_rd_valid    (o_mem_rd_valid),
        .i_mem_rd_ready    (i_mem_rd_ready),
        .o_mem_rd_addr     (o_mem_rd_addr),
        .i_mem_rdata_valid (i_mem_rdata_valid),
        .o_mem_wr_valid    (o_mem_wr_valid),
        .i_mem_wr_ready    (i_mem_wr_ready),
        .o_mem_wr_addr     (o_mem_wr_addr),
        .o_mem_wr_last     (o_mem_wr_last),
        .i_mem_wr_done     (i_mem_wr_done),
        .o_beat_clear      (beat_clear),
        .o_beat_step       (beat_step),
        .i_beat_last       (beat_last)
    );

    tag_store u_tags (
        .clk  (clk),
        .rstn (rstn),
        .ctrl (ctrl_if.tags)
    );

    line_datapath u_data (
        .clk               (clk),
        .rstn              (rstn),
        .ctrl              (ctrl_if.data),
        .i_mem_rdata_valid (i_mem_rdata_valid),
        .i_mem_rdata       (i_mem_rdata),
        .o_mem_wr_data     (o_mem_wr_data),
        .o_resp_rdata      (o_resp_rdata)
    );

    beat_counter u_beats (
        .clk     (clk),
        .rstn    (rstn),
        .i_clear (beat_clear),
        .i_step  (beat_step),
        .o_last  (beat_last)
    );

endmodule

`default_nettype wire

/* testbench/cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_tb;

    localparam int          NUM_REQS       = 320;
    localparam int          TIMEOUT_CYCLES = NUM_REQS * 200 + 10;
    localparam logic [31:0] FILL_KEY       = 32'h5A3C_96E1;

    logic        clk;
    logic        rstn;
    logic        i_req_valid;
    logic        o_req_ready;
    logic        i_req_write;
    logic [31:0] i_req_addr;
    logic [31:0] i_req_wdata;
    logic [3:0]  i_req_wstrb;
    logic        o_resp_valid;
    logic [31:0] o_resp_rdata;
    logic        o_mem_rd_valid;
    logic        i_mem_rd_ready;
    logic [31:0] o_mem_rd_addr;
    logic        i_mem_rdata_valid;
    logic [31:0] i_mem_rdata;
    logic        o_mem_wr_valid;
    logic        i_mem_wr_ready;
    logic [31:0] o_mem_wr_addr;
    logic [31:0] o_mem_wr_data;
    logic        o_mem_wr_last;
    logic        i_mem_wr_done;

    integer      seed = 32'h372e4f11;
    int          cycle = 0;
    int          accept_cycle = 0;
    int          last_latency = 0;
    int          resp_count = 0;
    int          rd_bursts = 0;
    int          wb_bursts = 0;
    int          bursts_before;
    logic [31:0] last_wb_addr = 32'h0;
    logic [31:0] mem_words [0:4095];   // word addressed backing memory
    logic [31:0] shadow [0:4095];      // what the cache should look like
    logic        exp_write_q [$];
    logic [31:0] exp_data_q [$];
    logic        exp_write;
    logic [31:0] exp_data;
    logic [31:0] rnd;

    cache_top dut0 (
        .clk (clk), .rstn (rstn),
        .i_req_valid (i_req_valid), .o_req_ready (o_req_ready),
        .i_req_write (i_req_write), .i_req_addr (i_req_addr),
        .i_req_wdata (i_req_wdata), .i_req_wstrb (i_req_wstrb),
        .o_resp_valid (o_resp_valid), .o_resp_rdata (o_resp_rdata),
        .o_mem_rd_valid (o_mem_rd_valid), .i_mem_rd_ready (i_mem_rd_ready),
        .o_mem_rd_addr (o_mem_rd_addr), .i_mem_rdata_valid (i_mem_rdata_valid),
        .i_mem_rdata (i_mem_rdata), .o_mem_wr_valid (o_mem_wr_valid),
        .i_mem_wr_ready (i_mem_wr_ready), .o_mem_wr_addr (o_mem_wr_addr),
        .o_mem_wr_data (o_mem_wr_data), .o_mem_wr_last (o_mem_wr_last),
        .i_mem_wr_done (i_mem_wr_done)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic check(input string what, input logic [31:0] got,
                         input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERROR at %0t: %s got %h expected %h", $time, what, got, expected);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // byte lanes with a strobe take the new data
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) result[8*b +: 8] = new_word[8*b +: 8];
        end
        return result;
    endfunction

    function automatic logic [31:0] expected_read(input logic [31:0] addr);
        return shadow[addr[13:2]];
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int index, input int word);
        return 32'((tag << 8) | (index << 4) | (word << 2));
    endfunction

    task automatic issue_request(input logic write, input logic [31:0] addr,
                                 input logic [31:0] wdata, input logic [3:0] wstrb);
        int start;
        start = resp_count;
        if (write) begin
            shadow[addr[13:2]] = merge_bytes(shadow[addr[13:2]], wdata, wstrb);
            exp_data_q.push_back(32'h0);
        end else begin
            exp_data_q.push_back(expected_read(addr));
        end
        exp_write_q.push_back(write);
        i_req_valid = 1'b1;
        i_req_write = write;
        i_req_addr  = addr;
        i_req_wdata = wdata;
        i_req_wstrb = wstrb;
        while (!o_req_ready) @(negedge clk);
        accept_cycle = cycle + 1;   // edge that takes the request
        @(negedge clk);
        i_req_valid = 1'b0;
        wait (resp_count != start);
        @(negedge clk);
    endtask

    task automatic read_word(input logic [31:0] addr);
        issue_request(1'b0, addr, 32'h0, 4'h0);
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] wstrb);
        issue_request(1'b1, addr, wdata, wstrb);
    endtask

    // compare each response pulse with the oldest expectation
    always @(negedge clk) begin
        if (rstn && o_resp_valid) begin
            if (exp_data_q.size() == 0) begin
                $display("response pulse at %0t without an outstanding request", $time);
                $display("Simulation failed");
                $fatal(1);
            end else begin
                exp_write = exp_write_q.pop_front();
                exp_data  = exp_data_q.pop_front();
                if (!exp_write) check("read data", o_resp_rdata, exp_data);
                last_latency = cycle + 1 - accept_cycle;
                resp_count   = resp_count + 1;
            end
        end
    end

    initial begin : mem_read_model
        int          gap;
        logic [11:0] base;
        i_mem_rd_ready    = 1'b0;
        i_mem_rdata_valid = 1'b0;
        i_mem_rdata       = 32'h0;
        forever begin
            @(negedge clk);
            if (o_mem_rd_valid) begin
                // refill fetches the line of the request in flight
                check("refill address", o_mem_rd_addr, {i_req_addr[31:4], 4'h0});
                base = o_mem_rd_addr[13:2];
                gap  = $random(seed) & 3;
                repeat (gap) @(negedge clk);
                i_mem_rd_ready = 1'b1;
                @(negedge clk);
                i_mem_rd_ready = 1'b0;
                rd_bursts = rd_bursts + 1;
                for (int b = 0; b < 4; b++) begin
                    gap = $random(seed) & 3;   // gaps between beats
                    repeat (gap) @(negedge clk);
                    i_mem_rdata       = mem_words[base + 12'(b)];
                    i_mem_rdata_valid = 1'b1;
                    @(negedge clk);
                    i_mem_rdata_valid = 1'b0;
                end
            end
        end
    end

    initial begin : mem_write_model
        int          gap;
        logic [11:0] widx;
        i_mem_wr_ready = 1'b0;
        i_mem_wr_done  = 1'b0;
        for (int i = 0; i < 4096; i++) mem_words[i] = 32'(i) ^ FILL_KEY;
        forever begin
            @(negedge clk);
            if (o_mem_wr_valid) begin
                last_wb_addr = o_mem_wr_addr;
                for (int b = 0; b < 4; b++) begin
                    gap = $random(seed) & 3;
                    repeat (gap) @(negedge clk);
                    widx = o_mem_wr_addr[13:2] + 12'(b);
                    mem_words[widx] = o_mem_wr_data;
                    check("write burst last flag", 32'(o_mem_wr_last), 32'(b == 3));
                    i_mem_wr_ready = 1'b1;
                    @(negedge clk);
                    i_mem_wr_ready = 1'b0;
                end
                wb_bursts = wb_bursts + 1;
                gap = $random(seed) & 3;
                repeat (gap) @(negedge clk);
                i_mem_wr_done = 1'b1;   // single cycle
                @(negedge clk);
                i_mem_wr_done = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run hung", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $fatal(1);
    end

    initial begin : stimulus
        rstn        = 1'b0;
        i_req_valid = 1'b0;
        i_req_write = 1'b0;
        i_req_addr  = 32'h0;
        i_req_wdata = 32'h0;
        i_req_wstrb = 4'h0;
        for (int i = 0; i < 4096; i++) shadow[i] = 32'(i) ^ FILL_KEY;
        repeat (10) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        check("ready after reset", 32'(o_req_ready), 32'd1);
        check("resp valid after reset", 32'(o_resp_valid), 32'd0);
        check("mem rd valid after reset", 32'(o_mem_rd_valid), 32'd0);
        check("mem wr valid after reset", 32'(o_mem_wr_valid), 32'd0);

        // cold read, then a hit in the same line
        bursts_before = rd_bursts;
        read_word(make_addr(1, 3, 2));
        check("cold read bursts", 32'(rd_bursts - bursts_before), 32'd1);
        read_word(make_addr(1, 3, 0));
        check("hit latency", 32'(last_latency), 32'd2);
        check("hit read bursts", 32'(rd_bursts - bursts_before), 32'd1);

        // partial store merged into the line
        write_word(make_addr(1, 3, 1), 32'hDEAD_BEEF, 4'b0101);
        read_word(make_addr(1, 3, 1));

        // three tags in set 5 force out a dirty line
        write_word(make_addr(2, 5, 0), 32'h1111_2222, 4'hF);
        write_word(make_addr(3, 5, 0), 32'h3333_4444, 4'hF);
        bursts_before = wb_bursts;
        write_word(make_addr(4, 5, 0), 32'h5555_6666, 4'hF);
        check("dirty eviction bursts", 32'(wb_bursts - bursts_before), 32'd1);
        check("written back line", last_wb_addr, make_addr(2, 5, 0));
        check("written back word", mem_words[make_addr(2, 5, 0) >> 2], 32'h1111_2222);
        read_word(make_addr(2, 5, 0));
        read_word(make_addr(3, 5, 0));

        // lru order A B A C in set 9
        read_word(make_addr(1, 9, 0));
        read_word(make_addr(2, 9, 0));
        read_word(make_addr(1, 9, 1));
        read_word(make_addr(3, 9, 0));
        bursts_before = rd_bursts;
        read_word(make_addr(1, 9, 2));
        check("lru keeps A", 32'(rd_bursts - bursts_before), 32'd0);
        read_word(make_addr(2, 9, 3));
        check("lru evicted B", 32'(rd_bursts - bursts_before), 32'd1);

        // random traffic over four tags in all sets
        for (int n = 0; n < 300; n++) begin
            rnd = $random(seed);
            if (rnd[10]) begin
                write_word({22'd0, rnd[9:2], 2'b00}, $random(seed), rnd[14:11]);
            end else begin
                read_word({22'd0, rnd[9:2], 2'b00});
            end
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* cache_top.f */
+incdir+source
source/cache_types_pkg.sv
source/cache_ctrl_pkg.sv
source/cache_ctrl_if.sv
source/cache_sram.sv
source/tag_store.sv
source/line_datapath.sv
source/beat_counter.sv
source/cache_ctrl_fsm.sv
source/cache_top.sv
testbench/cache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module cache_tb -f cache_top.f -o cache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/cache_sim)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -Fxq "Simulation completed successfully"; then
    exit 0
fi
exit 1
